//--- src/nocFlitPkg.sv
package nocFlitPkg;

  //////////////////////////////////////////////////
  // flit word layout
  //////////////////////////////////////////////////

  localparam int flitWidth    = 16;
  localparam int kindWidth    = 3;
  localparam int lengthWidth  = 12;
  localparam int payloadWidth = flitWidth - kindWidth;   // body uses all bits after kind

  typedef enum logic [kindWidth-1:0] {
    kindIdle   = 3'd0,
    kindHeader = 3'd1,
    kindBody   = 3'd2,
    kindTail   = 3'd3
  } flitKind;

  typedef struct packed {
    flitKind                kind;
    logic                   spare;    // reserved
    logic [lengthWidth-1:0] length;   // flits that follow the header
  } flitHeader;

  typedef struct packed {
    flitKind                 kind;
    logic [payloadWidth-1:0] payload;
  } flitBody;

  // one word, two readings picked by the kind field
  typedef union packed {
    flitHeader header;
    flitBody   body;
  } flitWord;

  localparam flitWord idleFlit = '0;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic isHeaderFlit(flitWord f);
    return f.header.kind == kindHeader;
  endfunction

endpackage

//--- src/nocPortPkg.sv
package nocPortPkg;

  //////////////////////////////////////////////////
  // router ports
  //////////////////////////////////////////////////

  localparam int numPorts = 5;

  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portIdx;

  //////////////////////////////////////////////////
  // grant encoding
  //////////////////////////////////////////////////

  typedef logic [numPorts-1:0] grantVec;   // one-hot per port

  localparam grantVec grantIdle = '0;

  // cyclic successor, south wraps back to local
  function automatic portIdx nextPort(portIdx p);
    return (p == portSouth) ? portLocal : portIdx'(p + 3'd1);
  endfunction

  function automatic grantVec portGrant(portIdx p);
    return grantVec'(1) << p;
  endfunction

endpackage

//--- src/portReqIf.sv
`timescale 1ns/10ps

interface portReqIf
  import nocFlitPkg::*, nocPortPkg::*;
();

  //////////////////////////////////////////////////
  // registered per-port state from the decode stage
  //////////////////////////////////////////////////

  logic [numPorts-1:0]    req;                    // valid levels
  flitWord                flit      [numPorts];   // flits, one stage late
  logic [lengthWidth-1:0] pktLength [numPorts];   // length of the last header seen

  // decode stage writes everything
  modport decoder (
    output req,
    output flit,
    output pktLength
  );

  modport arbiter (
    input req,
    input pktLength
  );

  modport crossbar (
    input flit
  );

endinterface

//--- src/holdTimer.sv
`timescale 1ns/10ps

module holdTimer
  import nocFlitPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   run,
  input  logic [lengthWidth-1:0] limit,
  output logic                   expired
);

  logic [lengthWidth-1:0] count;   // held cycles after the first

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (!run)
    begin
      count <= '0;   // restart whenever the hold is broken
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  assign expired = (count == limit);

  // once the limit is reached the arbiter has to let the port go
  holdStopsAtLimit: assert property (
    @(posedge clk) disable iff (rst)
    run |-> !expired
  ) else $error("hold timer kept running at its limit");

endmodule

//--- src/flitDecoder.sv
`timescale 1ns/10ps

module flitDecoder
  import nocFlitPkg::*, nocPortPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flitWord             inFlit [numPorts],
  input  logic [numPorts-1:0] inValid,
  portReqIf.decoder           reqBus
);

  //////////////////////////////////////////////////
  // request levels and packet lengths
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      reqBus.req <= '0;
      for (int i = 0; i < numPorts; i++)
      begin
        reqBus.pktLength[i] <= '0;
      end
    end
    else
    begin
      reqBus.req <= inValid;
      for (int i = 0; i < numPorts; i++)
      begin
        if (inValid[i] && isHeaderFlit(inFlit[i]))
        begin
          reqBus.pktLength[i] <= inFlit[i].header.length;   // new hold limit
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // flit pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < numPorts; i++)
    begin
      reqBus.flit[i] <= inFlit[i];
    end
  end

endmodule

//--- src/outputArbiter.sv
`timescale 1ns/10ps

module outputArbiter
  import nocPortPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  portReqIf.arbiter reqBus,
  output grantVec   grant
);

  portIdx              heldPort;    // port granted last cycle
  logic                heldValid;   // low while idle
  portIdx              nextHeld;
  logic                holdOk;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] expired;

  //////////////////////////////////////////////////
  // per-port hold timers
  //////////////////////////////////////////////////

  for (genvar i = 0; i < numPorts; i++)
  begin : genTimer
    holdTimer timer (
      .clk     (clk),
      .rst     (rst),
      .run     (runTimer[i]),
      .limit   (reqBus.pktLength[i]),
      .expired (expired[i])
    );
  end

  //////////////////////////////////////////////////
  // hold, then rotate
  //////////////////////////////////////////////////

  assign holdOk = heldValid && reqBus.req[heldPort] && !expired[heldPort];

  always_comb
  begin
    portIdx cand;
    logic   found;
    grant    = grantIdle;
    runTimer = '0;
    nextHeld = heldPort;
    found    = 1'b0;
    cand     = heldValid ? nextPort(heldPort) : portLocal;   // idle starts at local
    if (holdOk)
    begin
      grant              = portGrant(heldPort);
      runTimer[heldPort] = 1'b1;
    end
    else
    begin
      // the released port itself comes last in the search
      for (int k = 0; k < numPorts; k++)
      begin
        if (!found && reqBus.req[cand])
        begin
          found    = 1'b1;
          grant    = portGrant(cand);
          nextHeld = cand;
        end
        cand = nextPort(cand);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      heldValid <= 1'b0;
      heldPort  <= portLocal;
    end
    else
    begin
      heldValid <= (grant != grantIdle);
      heldPort  <= nextHeld;
    end
  end

  // a released port waits behind every other requester
  releaseRotates: assert property (
    @(posedge clk) disable iff (rst)
    (heldValid && !holdOk && ((reqBus.req & ~portGrant(heldPort)) != '0))
      |-> !grant[heldPort]
  ) else $error("port %0d regranted ahead of requests %h", heldPort, reqBus.req);

  // work conserving, someone requesting always wins the output
  grantWhenRequested: assert property (
    @(posedge clk) disable iff (rst)
    (reqBus.req != '0) |-> (grant != grantIdle)
  ) else $error("requests %h left without a grant", reqBus.req);

endmodule

//--- src/outputCrossbar.sv
`timescale 1ns/10ps

module outputCrossbar
  import nocFlitPkg::*, nocPortPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  portReqIf.crossbar reqBus,
  input  grantVec    grant,
  output flitWord    outFlit,
  output logic       outValid
);

  flitWord selFlit;

  //////////////////////////////////////////////////
  // select and register
  //////////////////////////////////////////////////

  always_comb
  begin
    selFlit = idleFlit;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
      begin
        selFlit = reqBus.flit[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit  <= idleFlit;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit  <= selFlit;
      outValid <= (grant != grantIdle);   // strobe follows the grant
    end
  end

  // a multi-hot grant would leave the mux picking the highest port
  xbarSingleSource: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  ) else $error("crossbar sees multi-hot grant %h", grant);

endmodule

//--- src/nocOutputPort.sv
`timescale 1ns/10ps

module nocOutputPort
  import nocFlitPkg::*, nocPortPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flitWord             inFlit [numPorts],
  input  logic [numPorts-1:0] inValid,
  output flitWord             outFlit,
  output logic                outValid,
  output grantVec             grant
);

  //////////////////////////////////////////////////
  // decode -> arbitrate -> crossbar
  //////////////////////////////////////////////////

  portReqIf reqBus ();

  flitDecoder decodeStage (
    .clk     (clk),
    .rst     (rst),
    .inFlit  (inFlit),
    .inValid (inValid),
    .reqBus  (reqBus)
  );

  outputArbiter arbStage (
    .clk    (clk),
    .rst    (rst),
    .reqBus (reqBus),
    .grant  (grant)    // also visible at the top
  );

  outputCrossbar xbarStage (
    .clk      (clk),
    .rst      (rst),
    .reqBus   (reqBus),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

//--- verif/nocOutputChecker.sv
`timescale 1ns/10ps

module nocOutputChecker
  import nocFlitPkg::*, nocPortPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flitWord             inFlit [numPorts],
  input  logic [numPorts-1:0] inValid,
  input  flitWord             outFlit,
  input  logic                outValid,
  input  grantVec             grant,
  input  logic                runDone,
  output int                  mismatchCount,
  output int                  otherCount
);

  logic [numPorts-1:0]    mReq;                // requests as the decoder holds them
  flitWord                mFlit [numPorts];
  logic [lengthWidth-1:0] mLen  [numPorts];    // last header length per port
  logic                   mHolding;            // some port owns the output
  int                     mOwner;
  int                     mExtra;              // cycles held beyond the first one
  flitWord                expFlit;
  logic                   expValid;
  bit                     seenReq;
  bit                     starveDone;
  int                     grantCount [numPorts];

  //////////////////////////////////////////////////
  // rule model: hold while allowed, else rotate
  //////////////////////////////////////////////////

  function automatic bit holdsOn();
    return mHolding && mReq[mOwner] && (mExtra != int'(mLen[mOwner]));
  endfunction

  function automatic int pickWinner();
    int p;
    if (holdsOn())
      return mOwner;
    p = mHolding ? (mOwner + 1) % numPorts : 0;   // idle searches from local
    for (int k = 0; k < numPorts; k++)
    begin
      if (mReq[p])
        return p;
      p = (p + 1) % numPorts;
    end
    return -1;
  endfunction

  function automatic grantVec toGrant(int w);
    grantVec g;
    g = '0;
    if (w >= 0)
      g[w] = 1'b1;
    return g;
  endfunction

  always @(posedge clk)
  begin
    int w;
    bit hold;
    if (rst)
    begin
      mReq     = '0;
      mHolding = 1'b0;
      mOwner   = 0;
      mExtra   = 0;
      expFlit  = idleFlit;
      expValid = 1'b0;
      for (int i = 0; i < numPorts; i++)
        mLen[i] = '0;
    end
    else
    begin
      w        = pickWinner();
      hold     = holdsOn();
      expValid = (w >= 0);
      expFlit  = idleFlit;
      if (w >= 0)
      begin
        expFlit = mFlit[w];   // shows up on the output one edge later
        mOwner  = w;
      end
      mExtra   = hold ? mExtra + 1 : 0;
      mHolding = (w >= 0);
      mReq     = inValid;
      for (int i = 0; i < numPorts; i++)
        if (inValid[i] && inFlit[i].header.kind == kindHeader)
          mLen[i] = inFlit[i].header.length;
    end
    for (int i = 0; i < numPorts; i++)
      mFlit[i] = inFlit[i];   // flit register has no reset
  end

  //////////////////////////////////////////////////
  // compare mid cycle
  //////////////////////////////////////////////////

  always @(negedge clk)
  begin
    grantVec expGrant;
    if (rst)
    begin
      mismatchCount = 0;
      otherCount    = 0;
      seenReq       = 1'b0;
      starveDone    = 1'b0;
      for (int i = 0; i < numPorts; i++)
        grantCount[i] = 0;
    end
    else
    begin
      expGrant = toGrant(pickWinner());
      if (grant !== expGrant)
      begin
        $display("Mismatch grant expected %h actual %h", expGrant, grant);
        mismatchCount++;
      end
      if (outValid !== expValid)
      begin
        $display("Mismatch outValid expected %h actual %h", expValid, outValid);
        mismatchCount++;
      end
      if (outFlit !== expFlit)
      begin
        $display("Mismatch outFlit expected %h actual %h", expFlit, outFlit);
        mismatchCount++;
      end
      if (mReq != '0)
        seenReq = 1'b1;
      if (!seenReq && (grant !== grantIdle || outValid !== 1'b0))
      begin
        $display("output active after reset although no port has requested yet");
        otherCount++;
      end
      for (int i = 0; i < numPorts; i++)
        if (grant[i])
          grantCount[i]++;
      if (runDone && !starveDone)
      begin
        starveDone = 1'b1;
        for (int i = 0; i < numPorts; i++)
          if (grantCount[i] == 0)
          begin
            $display("port %0d was starved, it never received a grant", i);
            otherCount++;
          end
      end
    end
  end

endmodule

//--- verif/nocOutputPortTb.sv
`timescale 1ns/10ps

module nocOutputPortTb
  import nocFlitPkg::*, nocPortPkg::*;
();

  localparam int runCycles = 3000;
  localparam int drainWait = 20;

  logic                clk;
  logic                rst;
  flitWord             inFlit [numPorts];
  logic [numPorts-1:0] inValid;
  flitWord             outFlit;
  logic                outValid;
  grantVec             grant;
  logic                runDone;
  int                  mismatchCount;
  int                  otherCount;
  int                  timeouts;
  integer              seed;
  int                  bodiesLeft [numPorts];   // flits still owed by the open packet
  int                  gapLeft    [numPorts];

  nocOutputPort DUT (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .outFlit  (outFlit),
    .outValid (outValid),
    .grant    (grant)
  );

  nocOutputChecker scoreboard (
    .clk           (clk),
    .rst           (rst),
    .inFlit        (inFlit),
    .inValid       (inValid),
    .outFlit       (outFlit),
    .outValid      (outValid),
    .grant         (grant),
    .runDone       (runDone),
    .mismatchCount (mismatchCount),
    .otherCount    (otherCount)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #2 clk = ~clk;
    end
  end

  //////////////////////////////////////////////////
  // per-port packet generator
  //////////////////////////////////////////////////

  task automatic stepPort(int p);
    logic [31:0] rnd;
    flitWord     w;
    rnd = $random(seed);
    if (bodiesLeft[p] > 0 && rnd[2:0] == 3'd0)
    begin
      inValid[p] = 1'b0;   // short drop inside a packet
    end
    else if (bodiesLeft[p] > 0)
    begin
      w.body.kind    = (bodiesLeft[p] == 1) ? kindTail : kindBody;
      w.body.payload = rnd[payloadWidth+2:3];
      bodiesLeft[p]--;
      inFlit[p]  = w;
      inValid[p] = 1'b1;
      if (bodiesLeft[p] == 0)
        gapLeft[p] = int'(rnd[31:30]);   // zero gap means back-to-back headers
    end
    else if (gapLeft[p] > 0)
    begin
      gapLeft[p]--;
      inFlit[p]  = rnd[flitWidth-1:0];   // junk while invalid
      inValid[p] = 1'b0;
    end
    else
    begin
      w.header.kind   = kindHeader;
      w.header.spare  = 1'b0;
      w.header.length = lengthWidth'(rnd % 7);
      bodiesLeft[p]   = int'(w.header.length);
      gapLeft[p]      = int'(rnd[31:30]);
      inFlit[p]       = w;
      inValid[p]      = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    int waited;
    seed     = 62;
    rst      = 1'b1;
    runDone  = 1'b0;
    timeouts = 0;
    inValid  = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p]     = idleFlit;
      bodiesLeft[p] = 0;
      gapLeft[p]    = 3;   // a few quiet cycles after reset
    end
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;

    for (int c = 0; c < runCycles; c++)
    begin
      for (int p = 0; p < numPorts; p++)
        stepPort(p);
      @(posedge clk);
      #1;
    end

    inValid = '0;
    waited  = 0;
    while ((grant !== grantIdle || outValid !== 1'b0) && waited < drainWait)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (grant !== grantIdle || outValid !== 1'b0)
    begin
      $display("timeout: output still busy %0d cycles after the inputs went idle", waited);
      timeouts++;
    end

    runDone = 1'b1;
    @(negedge clk);
    #1;
    $display("errors: mismatches %0d, other %0d, timeouts %0d",
             mismatchCount, otherCount, timeouts);
    if (mismatchCount == 0 && otherCount == 0 && timeouts == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
src/nocFlitPkg.sv
src/nocPortPkg.sv
src/portReqIf.sv
src/holdTimer.sv
src/flitDecoder.sv
src/outputArbiter.sv
src/outputCrossbar.sv
src/nocOutputPort.sv
verif/nocOutputChecker.sv
verif/nocOutputPortTb.sv

//--- Makefile
# Verilator build and run for the NoC output port allocator

VERILATOR ?= verilator
TOP       ?= nocOutputPortTb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG := TB FAILED
PASS_MSG := TB PASSED

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
